// File: aura_backend.f
+incdir+logic
logic/backend_pkg.sv
logic/backend_if.sv
logic/backend_queue.sv
logic/ctrl_block.sv
logic/exe_block.sv
logic/aura_backend.sv
tb/aura_backend_tb.sv

// File: logic/aura_backend.sv
`default_nettype none
`include "backend_macros.svh"

module aura_backend (
    input  wire                  clk,
    input  wire                  i_rst,
    input  wire                  i_inst_vld,
    input  wire [2:0]            i_inst_op,
    input  wire [`BE_REG_W-1:0]  i_inst_rd,
    input  wire [`BE_REG_W-1:0]  i_inst_rs1,
    input  wire [`BE_REG_W-1:0]  i_inst_rs2,
    input  wire [11:0]           i_inst_imm,
    input  wire [`BE_FTQ_W-1:0]  i_inst_ftq_idx,
    output wire                  o_stall,
    output wire                  o_commit_vld,
    output wire [`BE_FTQ_W-1:0]  o_commit_ftq_idx,
    output wire [`BE_REG_W-1:0]  o_commit_rd,
    output wire [`BE_XLEN-1:0]   o_commit_data
);

    backend_pkg::fetch_entry_t inst;

    always_comb begin
        inst.op      = backend_pkg::alu_op_t'(i_inst_op);
        inst.rd      = i_inst_rd;
        inst.rs1     = i_inst_rs1;
        inst.rs2     = i_inst_rs2;
        inst.imm     = i_inst_imm;
        inst.ftq_idx = i_inst_ftq_idx;
    end

    backend_disp_if disp_if ();
    backend_wb_if   wb_if ();

    ctrl_block u_ctrl_block (
        .clk              (clk),
        .i_rst            (i_rst),
        .i_inst_vld       (i_inst_vld),
        .i_inst           (inst),
        .o_stall          (o_stall),
        .disp             (disp_if.ctrl),
        .wb               (wb_if.sink),
        .o_commit_vld     (o_commit_vld),
        .o_commit_ftq_idx (o_commit_ftq_idx),
        .o_commit_rd      (o_commit_rd),
        .o_commit_data    (o_commit_data)
    );

    exe_block u_exe_block (
        .clk   (clk),
        .i_rst (i_rst),
        .disp  (disp_if.exe),
        .wb    (wb_if.src)
    );

endmodule

`default_nettype wire

// File: logic/backend_if.sv
`default_nettype none

// Dispatch from the control block to the execution block.
interface backend_disp_if;
    logic                       deq_vld;
    backend_pkg::int_dq_entry_t deq_info;
    logic                       mark_vld;
    backend_pkg::reg_idx_t      mark_rd;
    logic                       stall;

    modport ctrl (
        output deq_vld,
        output deq_info,
        output mark_vld,
        output mark_rd,
        input  stall
    );

    modport exe (
        input  deq_vld,
        input  deq_info,
        input  mark_vld,
        input  mark_rd,
        output stall
    );
endinterface

// Result writeback. The ROB slot is reserved, so no back-pressure.
interface backend_wb_if;
    logic                  wb_vld;
    backend_pkg::wb_info_t wb_info;

    modport src (
        output wb_vld,
        output wb_info
    );

    modport sink (
        input  wb_vld,
        input  wb_info
    );
endinterface

`default_nettype wire

// File: logic/backend_macros.svh
`ifndef BACKEND_MACROS_SVH
`define BACKEND_MACROS_SVH

// Datapath and architectural registers.
`define BE_XLEN      32
`define BE_NUM_REGS  16
`define BE_REG_W     4

// Reorder buffer.
`define BE_ROB_DEPTH 8
`define BE_ROB_W     3

// Dispatch and result queues.
`define BE_DQ_DEPTH  4
`define BE_WBQ_DEPTH 4

// Fetch target queue index.
`define BE_FTQ_W     4

`endif

// File: logic/backend_pkg.sv
`default_nettype none
`include "backend_macros.svh"

package backend_pkg;

    // Unlisted codes execute as add.
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_ADDI = 3'd5
    } alu_op_t;

    typedef logic [`BE_REG_W-1:0] reg_idx_t;
    typedef logic [`BE_ROB_W-1:0] rob_idx_t;
    typedef logic [`BE_FTQ_W-1:0] ftq_idx_t;

    typedef struct packed {
        alu_op_t            op;
        reg_idx_t           rd;
        reg_idx_t           rs1;
        reg_idx_t           rs2;
        logic signed [11:0] imm;
        ftq_idx_t           ftq_idx;
    } fetch_entry_t;

    typedef struct packed {
        alu_op_t            op;
        reg_idx_t           rd;
        reg_idx_t           rs1;
        reg_idx_t           rs2;
        logic signed [11:0] imm;
        rob_idx_t           rob_idx;
    } int_dq_entry_t;

    typedef struct packed {
        rob_idx_t             rob_idx;
        reg_idx_t             rd;
        logic [`BE_XLEN-1:0]  data;
    } wb_info_t;

endpackage

`default_nettype wire

// File: logic/backend_queue.sv
`default_nettype none

module backend_queue #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  wire   clk,
    input  wire   i_rst,
    input  wire   i_push,
    input  wire T i_data,
    input  wire   i_pop,
    output T      o_data,
    output logic  o_empty,
    output logic  o_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T                 mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign o_empty = (count == '0);
    assign o_full  = (count == (PTR_W + 1)'(DEPTH));
    assign o_data  = mem[rd_ptr];

    assign do_pop  = i_pop && !o_empty;
    // A full queue still takes a push when the head leaves.
    assign do_push = i_push && (!o_full || do_pop);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/ctrl_block.sv
`default_nettype none
`include "backend_macros.svh"

module ctrl_block (
    input  wire                            clk,
    input  wire                            i_rst,
    input  wire                            i_inst_vld,
    input  wire backend_pkg::fetch_entry_t i_inst,
    output logic                           o_stall,
    backend_disp_if.ctrl                   disp,
    backend_wb_if.sink                     wb,
    output logic                           o_commit_vld,
    output backend_pkg::ftq_idx_t          o_commit_ftq_idx,
    output backend_pkg::reg_idx_t          o_commit_rd,
    output logic [`BE_XLEN-1:0]            o_commit_data
);

    backend_pkg::int_dq_entry_t dq_in;
    backend_pkg::int_dq_entry_t dq_head;
    logic                       dq_empty;
    logic                       dq_full;
    logic                       dq_pop;
    logic                       accept;

    backend_pkg::ftq_idx_t      rob_ftq  [`BE_ROB_DEPTH];
    backend_pkg::reg_idx_t      rob_rd   [`BE_ROB_DEPTH];
    logic [`BE_XLEN-1:0]        rob_data [`BE_ROB_DEPTH];
    logic [`BE_ROB_DEPTH-1:0]   rob_done;
    backend_pkg::rob_idx_t      rob_head;
    backend_pkg::rob_idx_t      rob_tail;
    logic [`BE_ROB_W:0]         rob_cnt;
    logic                       rob_full;
    logic                       commit;

    assign rob_full = (rob_cnt == (`BE_ROB_W + 1)'(`BE_ROB_DEPTH));
    assign o_stall  = dq_full || rob_full;
    assign accept   = i_inst_vld && !o_stall;

    // Entry carries its ROB slot instead of the FTQ index.
    always_comb begin
        dq_in.op      = i_inst.op;
        dq_in.rd      = i_inst.rd;
        dq_in.rs1     = i_inst.rs1;
        dq_in.rs2     = i_inst.rs2;
        dq_in.imm     = i_inst.imm;
        dq_in.rob_idx = rob_tail;
    end

    backend_queue #(
        .T     (backend_pkg::int_dq_entry_t),
        .DEPTH (`BE_DQ_DEPTH)
    ) u_dispatch_queue (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_push  (accept),
        .i_data  (dq_in),
        .i_pop   (dq_pop),
        .o_data  (dq_head),
        .o_empty (dq_empty),
        .o_full  (dq_full)
    );

    // Dispatch and destination mark share the cycle.
    assign dq_pop        = !dq_empty && !disp.stall;
    assign disp.deq_vld  = !dq_empty;
    assign disp.deq_info = dq_head;
    assign disp.mark_vld = dq_pop;
    assign disp.mark_rd  = dq_head.rd;

    // Done is only ever set on a live slot.
    assign commit           = rob_done[rob_head];
    assign o_commit_vld     = commit;
    assign o_commit_ftq_idx = rob_ftq[rob_head];
    assign o_commit_rd      = rob_rd[rob_head];
    assign o_commit_data    = rob_data[rob_head];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            rob_head <= '0;
            rob_tail <= '0;
            rob_cnt  <= '0;
            rob_done <= '0;
        end else begin
            if (accept) begin
                rob_tail <= rob_tail + 1'b1;
            end
            if (commit) begin
                rob_head           <= rob_head + 1'b1;
                rob_done[rob_head] <= 1'b0;
            end
            if (wb.wb_vld) begin
                rob_done[wb.wb_info.rob_idx] <= 1'b1;
            end
            if (accept && !commit) begin
                rob_cnt <= rob_cnt + 1'b1;
            end else if (commit && !accept) begin
                rob_cnt <= rob_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rob_ftq[rob_tail] <= i_inst.ftq_idx;
            rob_rd[rob_tail]  <= i_inst.rd;
        end
        if (wb.wb_vld) begin
            rob_data[wb.wb_info.rob_idx] <= wb.wb_info.data;
        end
    end

endmodule

`default_nettype wire

// File: logic/exe_block.sv
`default_nettype none
`include "backend_macros.svh"

module exe_block (
    input  wire         clk,
    input  wire         i_rst,
    backend_disp_if.exe disp,
    backend_wb_if.src   wb
);

    backend_pkg::int_dq_entry_t head;
    logic [`BE_XLEN-1:0]        regs    [`BE_NUM_REGS];
    backend_pkg::rob_idx_t      reg_tag [`BE_NUM_REGS];
    logic [`BE_NUM_REGS-1:0]    reg_rdy;
    logic [`BE_XLEN-1:0]        src1;
    logic [`BE_XLEN-1:0]        src2;
    logic [`BE_XLEN-1:0]        imm_ext;
    logic [`BE_XLEN-1:0]        alu_res;
    logic                       src_rdy;
    logic                       stall;
    logic                       issue;
    logic                       alu_vld;
    backend_pkg::wb_info_t      alu_out;
    backend_pkg::wb_info_t      wbq_head;
    logic                       wbq_empty;
    logic                       wbq_full;
    logic                       wb_sets_rdy;

    assign head    = disp.deq_info;
    assign src1    = regs[head.rs1];
    assign src2    = regs[head.rs2];
    assign imm_ext = `BE_XLEN'($signed(head.imm));

    // addi has no second source.
    assign src_rdy = reg_rdy[head.rs1]
                     && (reg_rdy[head.rs2] || head.op == backend_pkg::ALU_ADDI);
    assign stall      = !src_rdy || (wbq_full && alu_vld);
    assign disp.stall = stall;
    assign issue      = disp.deq_vld && !stall;

    always_comb begin
        case (head.op)
            backend_pkg::ALU_SUB:  alu_res = src1 - src2;
            backend_pkg::ALU_AND:  alu_res = src1 & src2;
            backend_pkg::ALU_OR:   alu_res = src1 | src2;
            backend_pkg::ALU_XOR:  alu_res = src1 ^ src2;
            backend_pkg::ALU_ADDI: alu_res = src1 + imm_ext;
            default:               alu_res = src1 + src2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            alu_vld <= 1'b0;
        end else begin
            alu_vld <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            alu_out.rob_idx <= head.rob_idx;
            alu_out.rd      <= head.rd;
            alu_out.data    <= alu_res;
        end
    end

    backend_queue #(
        .T     (backend_pkg::wb_info_t),
        .DEPTH (`BE_WBQ_DEPTH)
    ) u_result_queue (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_push  (alu_vld),
        .i_data  (alu_out),
        .i_pop   (!wbq_empty),
        .o_data  (wbq_head),
        .o_empty (wbq_empty),
        .o_full  (wbq_full)
    );

    assign wb.wb_vld  = !wbq_empty;
    assign wb.wb_info = wbq_head;

    // Only the newest writer of a register clears its pending state.
    assign wb_sets_rdy = (reg_tag[wbq_head.rd] == wbq_head.rob_idx)
                         && !(disp.mark_vld && disp.mark_rd == wbq_head.rd);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < `BE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            reg_rdy <= '1;
        end else begin
            if (!wbq_empty) begin
                regs[wbq_head.rd] <= wbq_head.data;
                if (wb_sets_rdy) begin
                    reg_rdy[wbq_head.rd] <= 1'b1;
                end
            end
            if (disp.mark_vld) begin
                reg_rdy[disp.mark_rd] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (disp.mark_vld) begin
            reg_tag[disp.mark_rd] <= head.rob_idx;
        end
    end

endmodule

`default_nettype wire

// File: tb/aura_backend_tb.sv
`default_nettype none
`include "backend_macros.svh"

module aura_backend_tb;

    localparam int N_DIRECT       = 4;
    localparam int N_RANDOM       = 300;
    localparam int N_CHAIN        = 60;
    localparam int N_BURST        = 100;
    localparam int N_TOTAL        = N_DIRECT + N_RANDOM + N_CHAIN + N_BURST;
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = N_TOTAL * 20 + RESET_CYCLES;

    logic                 clk = 1'b0;
    logic                 i_rst;
    logic                 i_inst_vld;
    logic [2:0]           i_inst_op;
    logic [`BE_REG_W-1:0] i_inst_rd;
    logic [`BE_REG_W-1:0] i_inst_rs1;
    logic [`BE_REG_W-1:0] i_inst_rs2;
    logic [11:0]          i_inst_imm;
    logic [`BE_FTQ_W-1:0] i_inst_ftq_idx;
    wire                  o_stall;
    wire                  o_commit_vld;
    wire [`BE_FTQ_W-1:0]  o_commit_ftq_idx;
    wire [`BE_REG_W-1:0]  o_commit_rd;
    wire [`BE_XLEN-1:0]   o_commit_data;

    logic [`BE_XLEN-1:0]  model_regs [`BE_NUM_REGS];
    logic [`BE_FTQ_W-1:0] exp_ftq  [$];
    logic [`BE_REG_W-1:0] exp_rd   [$];
    logic [`BE_XLEN-1:0]  exp_data [$];
    int                   accept_cnt = 0;
    int                   commit_cnt = 0;
    logic                 stall_seen = 1'b0;
    logic [`BE_FTQ_W-1:0] ftq_ctr    = '0;
    logic [`BE_REG_W-1:0] prev_rd;

    aura_backend i_aura_backend (
        .clk              (clk),
        .i_rst            (i_rst),
        .i_inst_vld       (i_inst_vld),
        .i_inst_op        (i_inst_op),
        .i_inst_rd        (i_inst_rd),
        .i_inst_rs1       (i_inst_rs1),
        .i_inst_rs2       (i_inst_rs2),
        .i_inst_imm       (i_inst_imm),
        .i_inst_ftq_idx   (i_inst_ftq_idx),
        .o_stall          (o_stall),
        .o_commit_vld     (o_commit_vld),
        .o_commit_ftq_idx (o_commit_ftq_idx),
        .o_commit_rd      (o_commit_rd),
        .o_commit_data    (o_commit_data)
    );

    always #4 clk = ~clk;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    // Sequential execution of one accepted instruction.
    task automatic model_accept();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        a = model_regs[i_inst_rs1];
        b = model_regs[i_inst_rs2];
        case (i_inst_op)
            3'd1:    res = a - b;
            3'd2:    res = a & b;
            3'd3:    res = a | b;
            3'd4:    res = a ^ b;
            3'd5:    res = a + {{20{i_inst_imm[11]}}, i_inst_imm};
            default: res = a + b;
        endcase
        model_regs[i_inst_rd] = res;
        exp_ftq.push_back(i_inst_ftq_idx);
        exp_rd.push_back(i_inst_rd);
        exp_data.push_back(res);
        accept_cnt++;
    endtask

    task automatic check_commit();
        if (exp_data.size() == 0) begin
            $display("commit at %0t with no accepted instruction outstanding", $time);
            $display("*** FAILED ***");
            $fatal(1);
        end else begin
            compare("o_commit_ftq_idx", 32'(o_commit_ftq_idx), 32'(exp_ftq.pop_front()));
            compare("o_commit_rd", 32'(o_commit_rd), 32'(exp_rd.pop_front()));
            compare("o_commit_data", o_commit_data, exp_data.pop_front());
            commit_cnt++;
        end
    endtask

    always @(posedge clk) begin
        if (!i_rst) begin
            if (i_inst_vld && o_stall) begin
                stall_seen = 1'b1;
            end
            if (i_inst_vld && !o_stall) begin
                model_accept();
            end
            if (o_commit_vld) begin
                check_commit();
            end
        end
    end

    // Called on a falling edge; holds the instruction until it is taken.
    task automatic send_inst(input logic [2:0] op, input logic [3:0] rd, input logic [3:0] rs1,
                             input logic [3:0] rs2, input logic [11:0] imm);
        logic took;
        i_inst_vld     = 1'b1;
        i_inst_op      = op;
        i_inst_rd      = rd;
        i_inst_rs1     = rs1;
        i_inst_rs2     = rs2;
        i_inst_imm     = imm;
        i_inst_ftq_idx = ftq_ctr;
        do begin
            @(posedge clk);
            took = !o_stall;
            @(negedge clk);
        end while (!took);
        ftq_ctr = ftq_ctr + 1'b1;
        prev_rd = rd;
    endtask

    task automatic idle_cycles(input int n);
        i_inst_vld = 1'b0;
        i_inst_op  = 3'($urandom);
        i_inst_rd  = 4'($urandom);
        i_inst_imm = 12'($urandom);
        repeat (n) @(negedge clk);
    endtask

    initial begin
        #(TIMEOUT_CYCLES * 8);
        $display("watchdog timeout at %0t with %0d of %0d commits", $time, commit_cnt,
                 accept_cnt);
        $display("*** FAILED ***");
        $fatal(1);
    end

    initial begin
        void'($urandom(5));
        for (int i = 0; i < `BE_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        i_rst          = 1'b1;
        i_inst_vld     = 1'b0;
        i_inst_op      = '0;
        i_inst_rd      = '0;
        i_inst_rs1     = '0;
        i_inst_rs2     = '0;
        i_inst_imm     = '0;
        i_inst_ftq_idx = '0;
        prev_rd        = '0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            compare("o_stall", 32'(o_stall), 32'd0);
            compare("o_commit_vld", 32'(o_commit_vld), 32'd0);
        end
        i_rst = 1'b0;
        @(negedge clk);
        compare("o_stall", 32'(o_stall), 32'd0);
        compare("o_commit_vld", 32'(o_commit_vld), 32'd0);

        // Negative immediate and wrapping subtract from zeroed registers.
        send_inst(3'd5, 4'd1, 4'd0, 4'd0, 12'hffb);
        send_inst(3'd1, 4'd2, 4'd0, 4'd1, 12'h000);
        send_inst(3'd1, 4'd3, 4'd1, 4'd2, 12'h000);
        send_inst(3'd5, 4'd4, 4'd3, 4'd0, 12'h800);
        idle_cycles(4);

        for (int i = 0; i < N_RANDOM; i++) begin
            send_inst(3'($urandom), 4'($urandom), 4'($urandom), 4'($urandom), 12'($urandom));
            idle_cycles($urandom_range(0, 3));
        end

        // Each instruction reads the previous destination.
        for (int i = 0; i < N_CHAIN; i++) begin
            if (i % 3 == 0) begin
                send_inst(3'($urandom), prev_rd, prev_rd, prev_rd, 12'($urandom));
            end else begin
                send_inst(3'($urandom), 4'($urandom), prev_rd, 4'($urandom), 12'($urandom));
            end
            idle_cycles($urandom_range(0, 1));
        end

        // No gaps, with dependencies to back up the dispatch queue.
        stall_seen = 1'b0;
        for (int i = 0; i < N_BURST; i++) begin
            if ($urandom_range(0, 1) == 0) begin
                send_inst(3'($urandom), 4'($urandom), prev_rd, 4'($urandom), 12'($urandom));
            end else begin
                send_inst(3'($urandom), 4'($urandom), 4'($urandom), 4'($urandom),
                          12'($urandom));
            end
        end
        idle_cycles(1);
        if (!stall_seen) begin
            $display("o_stall never went high while valid was held continuously");
            $display("*** FAILED ***");
            $fatal(1);
        end

        while (exp_data.size() != 0) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);

        if (commit_cnt == accept_cnt && accept_cnt == N_TOTAL) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("%0d accepted but %0d committed", accept_cnt, commit_cnt);
            $display("*** FAILED ***");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
